// File: source/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// frontend sizing, shared by rtl and testbench

// instructions per fetch block, 32 bits each
`define FETCH_WIDTH 4

// block size in bytes
// used for pc advance and block alignment
`define FETCH_BLK_BYTES (4 * `FETCH_WIDTH)

// first fetch address after reset
`define FETCH_RESET_PC 32'h1eceb000

// fetch queue entries, power of two
// IF1 keeps one entry in reserve for the in-flight response
`define FETCH_QUEUE_DEPTH 4

`endif

// File: source/fetch_pkg.sv
`include "fetch_config.svh"

package fetch_pkg;

    // one block of raw instruction words
    // word 0 sits at the lowest address
    typedef logic [`FETCH_WIDTH-1:0][31:0] fetch_block_t;

    // packet handed to the decoder
    // pc is the exact fetch pc, may be unaligned after a redirect
    typedef struct packed {
        logic [31:0]  pc;
        fetch_block_t insts;
    } fetch_packet_t;

    // block request to instruction memory
    typedef struct packed {
        // block address, low bits cleared
        logic [31:0] addr;
    } imem_req_t;

    // block response from instruction memory
    // no ready, IF1 always takes it
    typedef struct packed {
        fetch_block_t rdata;
    } imem_resp_t;

endpackage

// File: source/pc_gen.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

// IF0, fetch pc register
module pc_gen
import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        prev_rst,
    input  logic        backend_flush,
    input  logic [31:0] backend_redirect_pc,
    input  logic        pc_advance,
    output logic [31:0] fetch_pc
);

    // clears the offset inside a block
    localparam logic [31:0] BLK_MASK = ~(32'(`FETCH_BLK_BYTES) - 32'd1);

    // next sequential block, always aligned
    logic [31:0] seq_pc;

    // an unaligned redirect pc realigns here on its first advance
    assign seq_pc = (fetch_pc + 32'(`FETCH_BLK_BYTES)) & BLK_MASK;

    // priority reset, redirect, advance
    // flush wins even with no request accepted, so a redirect is never lost
    always_ff @(posedge clk) begin
        if (prev_rst) begin
            fetch_pc <= `FETCH_RESET_PC;
        end else if (backend_flush) begin
            fetch_pc <= backend_redirect_pc;
        end else if (pc_advance) begin
            fetch_pc <= seq_pc;
        end
    end

    // word alignment carries over from cycle to cycle
    // unless the backend redirects to a misaligned pc
    a_pc_word_aligned: assert property (
        @(posedge clk) disable iff (prev_rst)
        (fetch_pc[1:0] == 2'b00) && !(backend_flush && (backend_redirect_pc[1:0] != 2'b00))
        |=> (fetch_pc[1:0] == 2'b00)
    ) else $error("pc_gen: fetch_pc lost word alignment");

endmodule

// File: source/if1_stage.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

// IF1, one block request in flight at a time
module if1_stage
import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          prev_rst,
    input  logic          backend_flush,

    // from IF0
    input  logic [31:0]   fetch_pc,
    output logic          pc_advance,

    // instruction memory port
    output logic          imem_req_valid,
    input  logic          imem_req_ready,
    output imem_req_t     imem_req,
    input  logic          imem_resp_valid,
    input  imem_resp_t    imem_resp,

    // fetch queue port
    input  logic          almost_full,
    output logic          enq_valid,
    output fetch_packet_t enq_data
);

    localparam logic [31:0] BLK_MASK = ~(32'(`FETCH_BLK_BYTES) - 32'd1);

    // request accepted, response not yet back
    logic        req_pending;
    // flush seen while pending, response gets dropped
    logic        req_stale;
    // exact pc the pending request was issued for
    logic [31:0] req_pc;
    logic        req_fire;

    // no new request while one is in flight or the queue lacks room
    // held off during a flush, fetch_pc is about to be replaced
    // low in reset so memory sees nothing before the first real pc
    assign imem_req_valid = !prev_rst && !req_pending && !almost_full && !backend_flush;

    // memory only sees the aligned block address
    assign imem_req.addr = fetch_pc & BLK_MASK;

    assign req_fire = imem_req_valid && imem_req_ready;

    // IF0 moves on once memory has taken the block
    assign pc_advance = req_fire;

    // outstanding request tracking
    always_ff @(posedge clk) begin
        if (prev_rst) begin
            req_pending <= 1'b0;
            req_stale   <= 1'b0;
        end else begin
            if (req_fire) begin
                req_pending <= 1'b1;
                req_stale   <= 1'b0;
            end else if (imem_resp_valid) begin
                // response closes the request, stale or not
                req_pending <= 1'b0;
                req_stale   <= 1'b0;
            end else if (backend_flush && req_pending) begin
                req_stale <= 1'b1;
            end
        end
    end

    // pc of the in-flight request
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_pc <= fetch_pc;
        end
    end

    // response goes straight into the queue in the same cycle
    // stale responses and those hit by a flush this cycle are dropped
    assign enq_valid = imem_resp_valid && req_pending && !req_stale && !backend_flush;

    // packet keeps the exact request pc, data from memory
    assign enq_data.pc    = req_pc;
    assign enq_data.insts = imem_resp.rdata;

    // after an accepted request nothing new goes out until its response returns
    a_single_outstanding: assert property (
        @(posedge clk) disable iff (prev_rst)
        req_fire |=> (!imem_req_valid until imem_resp_valid)
    ) else $error("if1_stage: second request while one is outstanding");

    // memory must not answer a request it never accepted
    a_resp_has_req: assert property (
        @(posedge clk) disable iff (prev_rst)
        imem_resp_valid |-> req_pending
    ) else $error("if1_stage: response with no request outstanding");

endmodule

// File: source/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

// flushable circular FIFO between IF1 and the decoder
module fetch_queue
import fetch_pkg::*;
#(
    parameter int unsigned DEPTH     = `FETCH_QUEUE_DEPTH,
    parameter type         payload_t = fetch_packet_t
) (
    input  logic     clk,
    input  logic     prev_rst,
    input  logic     flush,

    // write side, never refused
    input  logic     enq_valid,
    input  payload_t enq_data,
    output logic     almost_full,

    // read side
    output logic     deq_valid,
    input  logic     deq_ready,
    output payload_t deq_data
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    // one extra bit so count can reach DEPTH
    localparam int unsigned CNT_W = PTR_W + 1;

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    // entries held, plus the one being written now
    logic [CNT_W-1:0]   used_slots;
    logic               enq_fire;
    logic               deq_fire;

    // flush kills both sides in the same cycle
    assign enq_fire = enq_valid && !flush;
    assign deq_fire = deq_valid && deq_ready && !flush;

    // head entry visible the cycle after it was written
    assign deq_valid = (count != '0);
    assign deq_data  = mem[rd_ptr];

    // dequeue this cycle ignored, keeps fetch_ready off the request path
    assign used_slots  = count + CNT_W'(enq_valid);
    assign almost_full = (used_slots >= CNT_W'(DEPTH - 1));

    // pointers wrap on their own, DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (prev_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({enq_fire, deq_fire})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // IF1 flow control via almost_full must keep writes off a full queue
    a_no_enq_when_full: assert property (
        @(posedge clk) disable iff (prev_rst)
        enq_fire |-> (count != CNT_W'(DEPTH))
    ) else $error("fetch_queue: enqueue into a full queue");

endmodule

// File: source/frontend_top.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

// fetch frontend, IF0 -> IF1 -> fetch queue
module frontend_top
import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          prev_rst,

    // redirect from the backend
    input  logic          backend_flush,
    input  logic [31:0]   backend_redirect_pc,

    // instruction memory
    output logic          imem_req_valid,
    input  logic          imem_req_ready,
    output imem_req_t     imem_req,
    input  logic          imem_resp_valid,
    input  imem_resp_t    imem_resp,

    // decoder side
    output logic          fetch_valid,
    input  logic          fetch_ready,
    output fetch_packet_t fetch_packet
);

    // IF0 <-> IF1
    logic          pc_advance;
    logic [31:0]   fetch_pc;

    // IF1 <-> queue
    logic          almost_full;
    logic          enq_valid;
    fetch_packet_t enq_data;

    pc_gen i_pc_gen (
        .clk                 (clk),
        .prev_rst            (prev_rst),
        .backend_flush       (backend_flush),
        .backend_redirect_pc (backend_redirect_pc),
        .pc_advance          (pc_advance),
        .fetch_pc            (fetch_pc)
    );

    if1_stage i_if1_stage (
        .clk             (clk),
        .prev_rst        (prev_rst),
        .backend_flush   (backend_flush),
        .fetch_pc        (fetch_pc),
        .pc_advance      (pc_advance),
        .imem_req_valid  (imem_req_valid),
        .imem_req_ready  (imem_req_ready),
        .imem_req        (imem_req),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp       (imem_resp),
        .almost_full     (almost_full),
        .enq_valid       (enq_valid),
        .enq_data        (enq_data)
    );

    // flushed together with IF1, packets behind a redirect are dropped
    fetch_queue #(
        .DEPTH     (`FETCH_QUEUE_DEPTH),
        .payload_t (fetch_packet_t)
    ) i_fetch_queue (
        .clk         (clk),
        .prev_rst    (prev_rst),
        .flush       (backend_flush),
        .enq_valid   (enq_valid),
        .enq_data    (enq_data),
        .almost_full (almost_full),
        .deq_valid   (fetch_valid),
        .deq_ready   (fetch_ready),
        .deq_data    (fetch_packet)
    );

endmodule

// File: tests/imem_model.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

// instruction memory stand-in, one block per accepted request
module imem_model
import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       prev_rst,
    input  logic       req_valid,
    input  logic       req_ready,
    input  imem_req_t  req,
    output logic       resp_valid,
    output imem_resp_t resp
);

    int          seed = 32'h81354dee;
    logic        busy;
    int          wait_cnt;
    logic [31:0] blk_addr;
    int          k;

    // latency of 0 to 4 extra cycles per request
    always @(posedge clk) begin
        resp_valid <= 1'b0;
        if (prev_rst) begin
            busy     <= 1'b0;
            wait_cnt <= 0;
        end else if (req_valid && req_ready) begin
            busy     <= 1'b1;
            wait_cnt <= $unsigned($random(seed)) % 5;
            blk_addr <= req.addr & ~(32'(`FETCH_BLK_BYTES) - 32'd1);
        end else if (busy) begin
            if (wait_cnt == 0) begin
                busy       <= 1'b0;
                resp_valid <= 1'b1;
                // word k is its own address xor a fixed tag
                for (k = 0; k < `FETCH_WIDTH; k++) begin
                    resp.rdata[k] <= (blk_addr + 32'(4 * k)) ^ 32'hdead0000;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

// File: tests/tb_frontend.sv
`timescale 1ns/1ps
`include "fetch_config.svh"

module tb_frontend
import fetch_pkg::*;
();

    // 8 + 10 + 4 + 2 + 3 + 8 packets over all tests
    localparam int TOTAL_PACKETS   = 35;
    localparam int WATCHDOG_CYCLES = TOTAL_PACKETS * 20 + 200;

    logic          clk;
    logic          prev_rst;
    logic          backend_flush;
    logic [31:0]   backend_redirect_pc;
    logic          imem_req_valid;
    logic          imem_req_ready;
    imem_req_t     imem_req;
    logic          imem_resp_valid;
    imem_resp_t    imem_resp;
    logic          fetch_valid;
    logic          fetch_ready;
    fetch_packet_t fetch_packet;

    int            stall_seed = 32'h81354dee;
    int            req_count = 0;
    int            consumed = 0;
    logic          stall_done;
    // pc the next packet must carry
    logic [31:0]   expected_pc;
    // pc the next accepted request must be for
    logic [31:0]   next_req_pc;
    imem_req_t     exp_req;
    string         test_name = "reset";
    event          req_accepted;

    frontend_top i_frontend_top (
        .clk                 (clk),
        .prev_rst            (prev_rst),
        .backend_flush       (backend_flush),
        .backend_redirect_pc (backend_redirect_pc),
        .imem_req_valid      (imem_req_valid),
        .imem_req_ready      (imem_req_ready),
        .imem_req            (imem_req),
        .imem_resp_valid     (imem_resp_valid),
        .imem_resp           (imem_resp),
        .fetch_valid         (fetch_valid),
        .fetch_ready         (fetch_ready),
        .fetch_packet        (fetch_packet)
    );

    imem_model i_imem_model (
        .clk        (clk),
        .prev_rst   (prev_rst),
        .req_valid  (imem_req_valid),
        .req_ready  (imem_req_ready),
        .req        (imem_req),
        .resp_valid (imem_resp_valid),
        .resp       (imem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // counts blocks taken by memory and checks their block address
    always @(posedge clk) begin
        if (prev_rst) begin
            next_req_pc = `FETCH_RESET_PC;
        end else begin
            if (imem_req_valid && imem_req_ready) begin
                exp_req.addr = next_req_pc & ~(32'(`FETCH_BLK_BYTES) - 32'd1);
                compare_req(test_name, exp_req, imem_req);
                next_req_pc = (next_req_pc + 32'(`FETCH_BLK_BYTES))
                              & ~(32'(`FETCH_BLK_BYTES) - 32'd1);
                req_count++;
                -> req_accepted;
            end
            // redirect replaces the sequential step
            if (backend_flush) begin
                next_req_pc = backend_redirect_pc;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the frontend stopped delivering packets");
        abort_run();
    end

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic compare_packet(input string name, input fetch_packet_t exp,
                                  input fetch_packet_t act);
        if (exp !== act) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_req(input string name, input imem_req_t exp,
                               input imem_req_t act);
        if (exp !== act) begin
            $display("error %s: expected request %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (exp !== act) begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // exact pc, data from the enclosing block
    function automatic fetch_packet_t expected_packet(input logic [31:0] pc);
        fetch_packet_t p;
        logic [31:0]   base;
        int            k;
        base = pc & ~(32'(`FETCH_BLK_BYTES) - 32'd1);
        p.pc = pc;
        for (k = 0; k < `FETCH_WIDTH; k++) begin
            p.insts[k] = (base + 32'(4 * k)) ^ 32'hdead0000;
        end
        return p;
    endfunction

    // waits for fetch_valid, takes one packet, drops ready again
    task automatic check_next(input string name);
        fetch_packet_t pkt;
        @(negedge clk);
        while (!fetch_valid) begin
            @(negedge clk);
        end
        pkt = fetch_packet;
        fetch_ready = 1'b1;
        @(negedge clk);
        fetch_ready = 1'b0;
        consumed++;
        compare_packet(name, expected_packet(expected_pc), pkt);
        // next block is always aligned
        expected_pc = (expected_pc + 32'(`FETCH_BLK_BYTES)) & ~(32'(`FETCH_BLK_BYTES) - 32'd1);
    endtask

    // one cycle flush pulse
    task automatic redirect_to(input logic [31:0] pc);
        @(negedge clk);
        backend_flush = 1'b1;
        backend_redirect_pc = pc;
        @(negedge clk);
        backend_flush = 1'b0;
        expected_pc = pc;
    endtask

    task automatic test_sequential();
        test_name = "test_sequential";
        expected_pc = `FETCH_RESET_PC;
        repeat (8) check_next("test_sequential");
    endtask

    task automatic test_backpressure();
        int snap;
        test_name = "test_backpressure";
        // decoder stalled, queue fills and IF1 stops
        repeat (20) @(negedge clk);
        snap = req_count;
        repeat (10) @(negedge clk);
        compare_count("test_backpressure", snap, req_count);
        if (req_count - consumed > `FETCH_QUEUE_DEPTH) begin
            $display("test_backpressure: %0d blocks requested ahead of the decoder",
                     req_count - consumed);
            abort_run();
        end
        repeat (10) check_next("test_backpressure");
    endtask

    task automatic test_redirect();
        test_name = "test_redirect";
        redirect_to(32'h00402000);
        repeat (4) check_next("test_redirect");
    endtask

    task automatic test_unaligned_redirect();
        test_name = "test_unaligned_redirect";
        redirect_to(32'h00403008);
        repeat (2) check_next("test_unaligned_redirect");
    endtask

    task automatic test_flush_in_flight();
        test_name = "test_flush_in_flight";
        redirect_to(32'h00405000);
        // block at 0x00405000 now outstanding, flush before it returns
        @(req_accepted);
        redirect_to(32'h00406000);
        repeat (3) check_next("test_flush_in_flight");
    endtask

    task automatic test_memory_stall();
        int gap;
        test_name = "test_memory_stall";
        stall_done = 1'b0;
        fork
            begin
                while (!stall_done) begin
                    @(negedge clk);
                    imem_req_ready = 1'b0;
                    gap = $unsigned($random(stall_seed)) % 6;
                    repeat (gap) @(negedge clk);
                    @(negedge clk);
                    imem_req_ready = 1'b1;
                end
            end
            begin
                repeat (8) check_next("test_memory_stall");
                stall_done = 1'b1;
            end
        join
        @(negedge clk);
        imem_req_ready = 1'b1;
    endtask

    initial begin
        prev_rst            = 1'b1;
        backend_flush       = 1'b0;
        backend_redirect_pc = 32'h0;
        imem_req_ready      = 1'b1;
        fetch_ready         = 1'b0;
        expected_pc         = `FETCH_RESET_PC;
        stall_done          = 1'b0;
        // four rising edges in reset, release on the falling edge after
        repeat (4) @(posedge clk);
        @(negedge clk);
        prev_rst = 1'b0;
        test_sequential();
        test_backpressure();
        test_redirect();
        test_unaligned_redirect();
        test_flush_in_flight();
        test_memory_stall();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+source
source/fetch_pkg.sv
source/pc_gen.sv
source/if1_stage.sv
source/fetch_queue.sv
source/frontend_top.sv
tests/imem_model.sv
tests/tb_frontend.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - source
    files:
      - source/fetch_pkg.sv
      - source/pc_gen.sv
      - source/if1_stage.sv
      - source/fetch_queue.sv
      - source/frontend_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/imem_model.sv
      - tests/tb_frontend.sv
